// File: hw/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

  // three managers share two subordinates
  localparam int num_mgr = 3;

  // AXI-Lite write bus widths
  localparam int addr_w = 20;
  localparam int data_w = 16;
  localparam int strb_w = 2;

  // grant index into the manager arrays
  localparam int grant_w = 2;
  // one past the last manager, so it means no holder
  localparam logic [grant_w-1:0] grant_idle = 2'd3;

  // response-order fifo holds 2**fifo_addr_w outstanding writes
  localparam int fifo_addr_w = 3;

  // manager to interconnect, AW and W forward plus B ready
  typedef struct packed {
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              bready;
  } mgr_req_t;

  // interconnect back to a manager
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } mgr_rsp_t;

  // interconnect toward one subordinate
  typedef struct packed {
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              bready;
  } sub_req_t;

  // subordinate back to the interconnect
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } sub_rsp_t;

endpackage

`default_nettype wire

// File: hw/grant_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module grant_fifo
  import axi_xbar_pkg::*;
(
  input  logic               axi_clk,
  input  logic               axi_resetn,
  input  logic               push,
  input  logic [grant_w-1:0] push_data,
  input  logic               pop,
  output logic [grant_w-1:0] pop_data,
  output logic               empty,
  output logic               full
);

  // storage for granted manager indices, oldest at rd_ptr
  logic [grant_w-1:0] mem [2**fifo_addr_w];

  // top bit of each pointer is the wrap flag
  logic [fifo_addr_w:0] wr_ptr;
  logic [fifo_addr_w:0] rd_ptr;

  // same slot, same lap
  assign empty = wr_ptr == rd_ptr;
  // same slot, one lap apart
  assign full  = (wr_ptr[fifo_addr_w-1:0] == rd_ptr[fifo_addr_w-1:0]) &&
                 (wr_ptr[fifo_addr_w] != rd_ptr[fifo_addr_w]);

  assign pop_data = mem[rd_ptr[fifo_addr_w-1:0]];

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (push) begin
      mem[wr_ptr[fifo_addr_w-1:0]] <= push_data;
    end
  end

  // write port must hold off acceptance once all slots are in use
  assert property (@(posedge axi_clk) disable iff (!axi_resetn) push |-> !full);

  // a B handshake only happens while a response is routed from the head
  assert property (@(posedge axi_clk) disable iff (!axi_resetn) pop |-> !empty);

endmodule

`default_nettype wire

// File: hw/grant_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module grant_arbiter
  import axi_xbar_pkg::*;
(
  input  logic               axi_clk,
  input  logic               axi_resetn,
  input  logic [num_mgr-1:0] requesting,
  input  logic               txn_accepted,
  input  logic               txn_completed,
  output logic [grant_w-1:0] active_request,
  output logic [grant_w-1:0] active_response,
  output logic               outstanding_full
);

  logic [grant_w-1:0] next_grant;
  logic               idle;
  logic [grant_w-1:0] fifo_head;
  logic               fifo_empty;

  assign idle = active_request == grant_idle;

  // grant moves only when nobody holds it or the holder's request phase is done
  always_comb begin
    logic [num_mgr-1:0] holder_bit;
    logic [num_mgr-1:0] others;

    holder_bit = '0;
    next_grant = active_request;
    if (!idle) begin
      holder_bit[active_request] = 1'b1;
    end
    // everyone but the holder
    others = requesting & ~holder_bit;

    if (idle || txn_accepted) begin
      if (others != '0) begin
        // scan downwards so the lowest requesting index wins
        for (int i = num_mgr - 1; i >= 0; i--) begin
          if (others[i]) begin
            next_grant = grant_w'(i);
          end
        end
      end else if ((requesting & holder_bit) != '0) begin
        // holder has another write here and no one is waiting, skip the idle bubble
        next_grant = active_request;
      end else begin
        next_grant = grant_idle;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      active_request <= grant_idle;
    end else begin
      active_request <= next_grant;
    end
  end

  // accepted holders queue up here and wait for their B beat in order
  grant_fifo u_resp_fifo (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .push      (txn_accepted),
    .push_data (active_request),
    .pop       (txn_completed),
    .pop_data  (fifo_head),
    .empty     (fifo_empty),
    .full      (outstanding_full)
  );

  // no outstanding write means no B route
  assign active_response = fifo_empty ? grant_idle : fifo_head;

  // AW and W done flags in the port can only both be set under a real grant
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    txn_accepted |-> !idle);

endmodule

`default_nettype wire

// File: hw/axi_write_port.sv
`timescale 1ns/1ns
`default_nettype none

module axi_write_port
  import axi_xbar_pkg::*;
#(
  parameter int port_id = 0
) (
  input  logic     axi_clk,
  input  logic     axi_resetn,
  input  mgr_req_t mgr_req [num_mgr],
  output mgr_rsp_t mgr_rsp [num_mgr],
  output sub_req_t sub_req,
  input  sub_rsp_t sub_rsp
);

  logic [num_mgr-1:0] requesting;
  logic [grant_w-1:0] active_request;
  logic [grant_w-1:0] active_response;
  logic               outstanding_full;
  logic               granted;
  logic               responding;
  mgr_req_t           fwd;
  logic               aw_done;
  logic               w_done;
  logic               aw_fire;
  logic               w_fire;
  logic               txn_accepted;
  logic               txn_completed;

  assign granted    = active_request != grant_idle;
  assign responding = active_response != grant_idle;

  // handshakes as seen at the subordinate, identical to the manager side
  assign aw_fire = sub_req.awvalid && sub_rsp.awready;
  assign w_fire  = sub_req.wvalid && sub_rsp.wready;

  // request phase ends once both beats are in, either one possibly this cycle
  assign txn_accepted  = (aw_done || aw_fire) && (w_done || w_fire);
  assign txn_completed = sub_rsp.bvalid && sub_req.bready;

  // managers with a pending AW decoded to this port by address bit 0
  always_comb begin
    for (int m = 0; m < num_mgr; m++) begin
      requesting[m] = mgr_req[m].awvalid && (mgr_req[m].awaddr[0] == 1'(port_id));
    end
    // beat taken this cycle is not a new request from the holder
    if (aw_fire) begin
      requesting[active_request] = 1'b0;
    end
  end

  grant_arbiter u_arbiter (
    .axi_clk         (axi_clk),
    .axi_resetn      (axi_resetn),
    .requesting      (requesting),
    .txn_accepted    (txn_accepted),
    .txn_completed   (txn_completed),
    .active_request  (active_request),
    .active_response (active_response),
    .outstanding_full(outstanding_full)
  );

  // sticky flags, a beat that already went through is not sent again
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (txn_accepted) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      aw_done <= aw_done || aw_fire;
      w_done  <= w_done || w_fire;
    end
  end

  // granted manager's bus, all zero while idle
  always_comb begin
    fwd = '0;
    if (granted) begin
      fwd = mgr_req[active_request];
    end
  end

  // forward mux toward the subordinate
  always_comb begin
    sub_req.awaddr  = fwd.awaddr;
    // valids drop while the fifo is full so both sides agree on no transfer
    sub_req.awvalid = fwd.awvalid && !aw_done && !outstanding_full;
    sub_req.wdata   = fwd.wdata;
    sub_req.wstrb   = fwd.wstrb;
    sub_req.wvalid  = fwd.wvalid && !w_done && !outstanding_full;
    // B ready comes from whoever sits at the fifo head
    sub_req.bready  = responding ? mgr_req[active_response].bready : 1'b0;
  end

  // return mux, managers not being served see zeros
  always_comb begin
    for (int m = 0; m < num_mgr; m++) begin
      mgr_rsp[m] = '0;
    end
    if (granted) begin
      mgr_rsp[active_request].awready = sub_rsp.awready && !aw_done && !outstanding_full;
      mgr_rsp[active_request].wready  = sub_rsp.wready && !w_done && !outstanding_full;
    end
    if (responding) begin
      mgr_rsp[active_response].bvalid = sub_rsp.bvalid;
      mgr_rsp[active_response].bresp  = sub_rsp.bresp;
    end
  end

  // the grant only lands on a manager whose held AW decodes to this port
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    sub_req.awvalid |-> sub_req.awaddr[0] == 1'(port_id));

endmodule

`default_nettype wire

// File: hw/manager_merge.sv
`timescale 1ns/1ns
`default_nettype none

module manager_merge
  import axi_xbar_pkg::*;
(
  input  mgr_rsp_t port0_rsp [num_mgr],
  input  mgr_rsp_t port1_rsp [num_mgr],
  output mgr_rsp_t mgr_rsp   [num_mgr]
);

  // each port drives zeros toward managers it does not serve, so OR is enough
  always_comb begin
    for (int m = 0; m < num_mgr; m++) begin
      mgr_rsp[m].awready = port0_rsp[m].awready || port1_rsp[m].awready;
      mgr_rsp[m].wready  = port0_rsp[m].wready || port1_rsp[m].wready;
      mgr_rsp[m].bvalid  = port0_rsp[m].bvalid || port1_rsp[m].bvalid;
      // bresp follows the port that is returning
      if (port1_rsp[m].bvalid) begin
        mgr_rsp[m].bresp = port1_rsp[m].bresp;
      end else begin
        mgr_rsp[m].bresp = port0_rsp[m].bresp;
      end
    end
  end

  // two fifo heads naming the same manager at once would mean a lost response
  always_comb begin
    for (int m = 0; m < num_mgr; m++) begin
      assert (!(port0_rsp[m].bvalid && port1_rsp[m].bvalid))
        else $error("both ports return B to manager %0d", m);
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_wr_3to2.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wr_3to2
  import axi_xbar_pkg::*;
(
  input  logic              axi_clk,
  input  logic              axi_resetn,
  // manager 0
  input  logic [addr_w-1:0] in0_axi_awaddr,
  input  logic              in0_axi_awvalid,
  output logic              in0_axi_awready,
  input  logic [data_w-1:0] in0_axi_wdata,
  input  logic [strb_w-1:0] in0_axi_wstrb,
  input  logic              in0_axi_wvalid,
  output logic              in0_axi_wready,
  output logic [1:0]        in0_axi_bresp,
  output logic              in0_axi_bvalid,
  input  logic              in0_axi_bready,
  // manager 1
  input  logic [addr_w-1:0] in1_axi_awaddr,
  input  logic              in1_axi_awvalid,
  output logic              in1_axi_awready,
  input  logic [data_w-1:0] in1_axi_wdata,
  input  logic [strb_w-1:0] in1_axi_wstrb,
  input  logic              in1_axi_wvalid,
  output logic              in1_axi_wready,
  output logic [1:0]        in1_axi_bresp,
  output logic              in1_axi_bvalid,
  input  logic              in1_axi_bready,
  // manager 2
  input  logic [addr_w-1:0] in2_axi_awaddr,
  input  logic              in2_axi_awvalid,
  output logic              in2_axi_awready,
  input  logic [data_w-1:0] in2_axi_wdata,
  input  logic [strb_w-1:0] in2_axi_wstrb,
  input  logic              in2_axi_wvalid,
  output logic              in2_axi_wready,
  output logic [1:0]        in2_axi_bresp,
  output logic              in2_axi_bvalid,
  input  logic              in2_axi_bready,
  // subordinate 0, even addresses
  output logic [addr_w-1:0] out0_axi_awaddr,
  output logic              out0_axi_awvalid,
  input  logic              out0_axi_awready,
  output logic [data_w-1:0] out0_axi_wdata,
  output logic [strb_w-1:0] out0_axi_wstrb,
  output logic              out0_axi_wvalid,
  input  logic              out0_axi_wready,
  input  logic [1:0]        out0_axi_bresp,
  input  logic              out0_axi_bvalid,
  output logic              out0_axi_bready,
  // subordinate 1, odd addresses
  output logic [addr_w-1:0] out1_axi_awaddr,
  output logic              out1_axi_awvalid,
  input  logic              out1_axi_awready,
  output logic [data_w-1:0] out1_axi_wdata,
  output logic [strb_w-1:0] out1_axi_wstrb,
  output logic              out1_axi_wvalid,
  input  logic              out1_axi_wready,
  input  logic [1:0]        out1_axi_bresp,
  input  logic              out1_axi_bvalid,
  output logic              out1_axi_bready
);

  mgr_req_t mgr_req  [num_mgr];
  mgr_rsp_t mgr_rsp  [num_mgr];
  // per port, per manager return signals before the merge
  mgr_rsp_t port_rsp [2][num_mgr];
  sub_req_t sub_req  [2];
  sub_rsp_t sub_rsp  [2];

  // concatenations follow struct field order
  assign mgr_req[0] = {in0_axi_awaddr, in0_axi_awvalid, in0_axi_wdata, in0_axi_wstrb,
                       in0_axi_wvalid, in0_axi_bready};
  assign mgr_req[1] = {in1_axi_awaddr, in1_axi_awvalid, in1_axi_wdata, in1_axi_wstrb,
                       in1_axi_wvalid, in1_axi_bready};
  assign mgr_req[2] = {in2_axi_awaddr, in2_axi_awvalid, in2_axi_wdata, in2_axi_wstrb,
                       in2_axi_wvalid, in2_axi_bready};

  assign {in0_axi_awready, in0_axi_wready, in0_axi_bvalid, in0_axi_bresp} = mgr_rsp[0];
  assign {in1_axi_awready, in1_axi_wready, in1_axi_bvalid, in1_axi_bresp} = mgr_rsp[1];
  assign {in2_axi_awready, in2_axi_wready, in2_axi_bvalid, in2_axi_bresp} = mgr_rsp[2];

  assign {out0_axi_awaddr, out0_axi_awvalid, out0_axi_wdata, out0_axi_wstrb,
          out0_axi_wvalid, out0_axi_bready} = sub_req[0];
  assign {out1_axi_awaddr, out1_axi_awvalid, out1_axi_wdata, out1_axi_wstrb,
          out1_axi_wvalid, out1_axi_bready} = sub_req[1];

  assign sub_rsp[0] = {out0_axi_awready, out0_axi_wready, out0_axi_bvalid, out0_axi_bresp};
  assign sub_rsp[1] = {out1_axi_awready, out1_axi_wready, out1_axi_bvalid, out1_axi_bresp};

  // one write port per subordinate, both see every manager
  for (genvar p = 0; p < 2; p++) begin : g_port
    axi_write_port #(
      .port_id(p)
    ) u_port (
      .axi_clk   (axi_clk),
      .axi_resetn(axi_resetn),
      .mgr_req   (mgr_req),
      .mgr_rsp   (port_rsp[p]),
      .sub_req   (sub_req[p]),
      .sub_rsp   (sub_rsp[p])
    );
  end

  manager_merge u_merge (
    .port0_rsp(port_rsp[0]),
    .port1_rsp(port_rsp[1]),
    .mgr_rsp  (mgr_rsp)
  );

endmodule

`default_nettype wire

// File: test/tb_axi_wr_3to2.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_wr_3to2
  import axi_xbar_pkg::*;
();

  localparam int num_writes  = 22;
  localparam int num_cols    = 6;
  localparam int col_mgr     = 0;
  localparam int col_addr    = 1;
  localparam int col_data    = 2;
  localparam int col_strb    = 3;
  localparam int col_sub     = 4;
  localparam int col_bresp   = 5;
  // managers 0 and 2 open with four sub 0 writes each
  localparam int fair_len    = 8;
  localparam int cycle_limit = 200 * num_writes;

  logic              axi_clk;
  logic              axi_resetn;
  // manager side
  logic [addr_w-1:0] m_awaddr  [num_mgr];
  logic              m_awvalid [num_mgr];
  logic              m_awready [num_mgr];
  logic [data_w-1:0] m_wdata   [num_mgr];
  logic [strb_w-1:0] m_wstrb   [num_mgr];
  logic              m_wvalid  [num_mgr];
  logic              m_wready  [num_mgr];
  logic [1:0]        m_bresp   [num_mgr];
  logic              m_bvalid  [num_mgr];
  logic              m_bready  [num_mgr];
  // subordinate side
  logic [addr_w-1:0] s_awaddr  [2];
  logic              s_awvalid [2];
  logic              s_awready [2];
  logic [data_w-1:0] s_wdata   [2];
  logic [strb_w-1:0] s_wstrb   [2];
  logic              s_wvalid  [2];
  logic              s_wready  [2];
  logic [1:0]        s_bresp   [2];
  logic              s_bvalid  [2];
  logic              s_bready  [2];

  // trace words, six per write
  logic [31:0] trace_mem [num_writes*num_cols];
  int          mgr_list  [num_mgr][num_writes];
  int          mgr_cnt   [num_mgr];

  // manager models
  int   issued  [num_mgr];
  int   b_cnt   [num_mgr];
  int   cur_sub [num_mgr];
  logic busy    [num_mgr];
  logic aw_sent [num_mgr];
  logic w_sent  [num_mgr];
  logic w_late  [num_mgr];

  // subordinate models and their logs
  logic [addr_w-1:0] log_addr    [2][num_writes];
  logic [data_w-1:0] log_data    [2][num_writes];
  logic [strb_w-1:0] log_strb    [2][num_writes];
  logic              log_overlap [2][num_writes];
  int                log_cnt     [2];
  int                b_sent      [2];
  logic              aw_got      [2];
  logic              w_got       [2];
  logic [addr_w-1:0] got_addr    [2];
  logic [data_w-1:0] got_data    [2];
  logic [strb_w-1:0] got_strb    [2];

  logic [31:0] lfsr         = 32'h5bb9_e6e2;
  int          errors       = 0;
  int          cycles       = 0;
  int          reset_cycles = 0;
  int          run_cycles   = 0;

  axi_wr_3to2 dut (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .in0_axi_awaddr(m_awaddr[0]), .in0_axi_awvalid(m_awvalid[0]), .in0_axi_awready(m_awready[0]),
    .in0_axi_wdata(m_wdata[0]), .in0_axi_wstrb(m_wstrb[0]), .in0_axi_wvalid(m_wvalid[0]),
    .in0_axi_wready(m_wready[0]), .in0_axi_bresp(m_bresp[0]), .in0_axi_bvalid(m_bvalid[0]),
    .in0_axi_bready(m_bready[0]),
    .in1_axi_awaddr(m_awaddr[1]), .in1_axi_awvalid(m_awvalid[1]), .in1_axi_awready(m_awready[1]),
    .in1_axi_wdata(m_wdata[1]), .in1_axi_wstrb(m_wstrb[1]), .in1_axi_wvalid(m_wvalid[1]),
    .in1_axi_wready(m_wready[1]), .in1_axi_bresp(m_bresp[1]), .in1_axi_bvalid(m_bvalid[1]),
    .in1_axi_bready(m_bready[1]),
    .in2_axi_awaddr(m_awaddr[2]), .in2_axi_awvalid(m_awvalid[2]), .in2_axi_awready(m_awready[2]),
    .in2_axi_wdata(m_wdata[2]), .in2_axi_wstrb(m_wstrb[2]), .in2_axi_wvalid(m_wvalid[2]),
    .in2_axi_wready(m_wready[2]), .in2_axi_bresp(m_bresp[2]), .in2_axi_bvalid(m_bvalid[2]),
    .in2_axi_bready(m_bready[2]),
    .out0_axi_awaddr(s_awaddr[0]), .out0_axi_awvalid(s_awvalid[0]),
    .out0_axi_awready(s_awready[0]), .out0_axi_wdata(s_wdata[0]), .out0_axi_wstrb(s_wstrb[0]),
    .out0_axi_wvalid(s_wvalid[0]), .out0_axi_wready(s_wready[0]), .out0_axi_bresp(s_bresp[0]),
    .out0_axi_bvalid(s_bvalid[0]), .out0_axi_bready(s_bready[0]),
    .out1_axi_awaddr(s_awaddr[1]), .out1_axi_awvalid(s_awvalid[1]),
    .out1_axi_awready(s_awready[1]), .out1_axi_wdata(s_wdata[1]), .out1_axi_wstrb(s_wstrb[1]),
    .out1_axi_wvalid(s_wvalid[1]), .out1_axi_wready(s_wready[1]), .out1_axi_bresp(s_bresp[1]),
    .out1_axi_bvalid(s_bvalid[1]), .out1_axi_bready(s_bready[1])
  );

  initial begin
    axi_clk = 1'b0;
    forever #2 axi_clk = ~axi_clk;
  end

  function automatic logic [31:0] trace_field(input int t, input int c);
    return trace_mem[t*num_cols + c];
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // trace line that carries this data word, -1 if none
  function automatic int find_write(input logic [data_w-1:0] d);
    for (int t = 0; t < num_writes; t++) begin
      if (data_w'(trace_field(t, col_data)) == d) begin
        return t;
      end
    end
    return -1;
  endfunction

  task automatic check_quiet(input string when);
    for (int p = 0; p < 2; p++) begin
      check_eq(s_awvalid[p], 0, $sformatf("out%0d awvalid %s", p, when));
      check_eq(s_wvalid[p], 0, $sformatf("out%0d wvalid %s", p, when));
      check_eq(s_bready[p], 0, $sformatf("out%0d bready %s", p, when));
    end
  endtask

  // B side of each manager, bready withheld at random
  task automatic collect_responses();
    int   t;
    logic rdy;
    for (int m = 0; m < num_mgr; m++) begin
      if (b_cnt[m] >= issued[m]) begin
        check_eq(m_bvalid[m], 0, $sformatf("in%0d bvalid with no write outstanding", m));
      end else if (m_bvalid[m] && m_bready[m]) begin
        t = mgr_list[m][b_cnt[m]];
        check_eq(m_bresp[m], trace_field(t, col_bresp), $sformatf("in%0d bresp, write %0d", m, t));
        b_cnt[m]++;
      end
      take_bit(rdy);
      m_bready[m] <= rdy;
    end
  endtask

  // AW and W side, one request phase at a time per manager
  task automatic drive_managers();
    int   t;
    logic late;
    for (int m = 0; m < num_mgr; m++) begin
      if (m_awvalid[m] && m_awready[m]) begin
        aw_sent[m] = 1'b1;
        m_awvalid[m] <= 1'b0;
      end
      if (m_wvalid[m] && m_wready[m]) begin
        w_sent[m] = 1'b1;
        m_wvalid[m] <= 1'b0;
      end
      // W trailing AW by a cycle
      if (w_late[m]) begin
        m_wvalid[m] <= 1'b1;
        w_late[m] = 1'b0;
      end
      if (busy[m] && aw_sent[m] && w_sent[m]) begin
        busy[m] = 1'b0;
        issued[m]++;
      end
      if (!busy[m] && issued[m] < mgr_cnt[m]) begin
        t = mgr_list[m][issued[m]];
        // switching subordinate waits for all B beats, keeps B in issue order
        if (b_cnt[m] == issued[m] || cur_sub[m] == int'(trace_field(t, col_sub))) begin
          m_awaddr[m]  <= addr_w'(trace_field(t, col_addr));
          m_wdata[m]   <= data_w'(trace_field(t, col_data));
          m_wstrb[m]   <= strb_w'(trace_field(t, col_strb));
          m_awvalid[m] <= 1'b1;
          take_bit(late);
          if (late) begin
            w_late[m] = 1'b1;
          end else begin
            m_wvalid[m] <= 1'b1;
          end
          busy[m]    = 1'b1;
          aw_sent[m] = 1'b0;
          w_sent[m]  = 1'b0;
          cur_sub[m] = int'(trace_field(t, col_sub));
        end
      end
    end
  endtask

  // random readies, in-order B with random delay, bresp from awaddr[2:1]
  task automatic model_subordinates();
    logic coin;
    logic b_busy;
    for (int p = 0; p < 2; p++) begin
      if (s_awvalid[p] && s_awready[p]) begin
        aw_got[p]   = 1'b1;
        got_addr[p] = s_awaddr[p];
      end
      if (s_wvalid[p] && s_wready[p]) begin
        w_got[p]    = 1'b1;
        got_data[p] = s_wdata[p];
        got_strb[p] = s_wstrb[p];
      end
      if (aw_got[p] && w_got[p]) begin
        if (log_cnt[p] < num_writes) begin
          log_addr[p][log_cnt[p]] = got_addr[p];
          log_data[p][log_cnt[p]] = got_data[p];
          log_strb[p][log_cnt[p]] = got_strb[p];
          // other subordinate still owes responses
          log_overlap[p][log_cnt[p]] = log_cnt[1-p] > b_sent[1-p];
          log_cnt[p]++;
        end else begin
          errors++;
          $display("out%0d received more writes than the trace holds", p);
        end
        aw_got[p] = 1'b0;
        w_got[p]  = 1'b0;
      end
      b_busy = s_bvalid[p] && !s_bready[p];
      if (s_bvalid[p] && s_bready[p]) begin
        b_sent[p]++;
      end
      if (!b_busy) begin
        take_bit(coin);
        if (b_sent[p] < log_cnt[p] && coin) begin
          s_bvalid[p] <= 1'b1;
          s_bresp[p]  <= log_addr[p][b_sent[p]][2:1];
        end else begin
          s_bvalid[p] <= 1'b0;
        end
      end
      take_bit(coin);
      s_awready[p] <= coin;
      take_bit(coin);
      s_wready[p] <= coin;
    end
  endtask

  // a manager ready implies the ready of its subordinate
  task automatic check_ready_path();
    int p;
    for (int m = 0; m < num_mgr; m++) begin
      p = int'(m_awaddr[m][0]);
      if (m_awready[m]) begin
        check_eq(s_awready[p], 1, $sformatf("in%0d awready while out%0d holds it low", m, p));
      end
      if (m_wready[m]) begin
        check_eq(s_wready[p], 1, $sformatf("in%0d wready while out%0d holds it low", m, p));
      end
    end
  endtask

  always @(posedge axi_clk) begin
    if (!axi_resetn) begin
      reset_cycles++;
      for (int m = 0; m < num_mgr; m++) begin
        issued[m]  = 0;
        b_cnt[m]   = 0;
        cur_sub[m] = 0;
        busy[m]    = 1'b0;
        aw_sent[m] = 1'b0;
        w_sent[m]  = 1'b0;
        w_late[m]  = 1'b0;
      end
      for (int p = 0; p < 2; p++) begin
        log_cnt[p] = 0;
        b_sent[p]  = 0;
        aw_got[p]  = 1'b0;
        w_got[p]   = 1'b0;
      end
      // first edge has not reset the DUT yet
      if (reset_cycles > 1) begin
        check_quiet("during reset");
      end
    end else begin
      run_cycles++;
      if (run_cycles <= 2) begin
        check_quiet("right after reset");
      end
      check_ready_path();
      collect_responses();
      drive_managers();
      model_subordinates();
    end
  end

  // routing, exactly once delivery, handover order, overlap
  task automatic check_logs();
    logic seen [num_writes];
    logic overlap [2];
    int   t;
    for (int i = 0; i < num_writes; i++) begin
      seen[i] = 1'b0;
    end
    for (int p = 0; p < 2; p++) begin
      overlap[p] = 1'b0;
      for (int k = 0; k < log_cnt[p]; k++) begin
        t = find_write(log_data[p][k]);
        if (t < 0) begin
          errors++;
          $display("out%0d received data %0h that no trace line holds", p, log_data[p][k]);
        end else begin
          check_eq(seen[t], 0, $sformatf("write %0d delivered twice", t));
          seen[t] = 1'b1;
          check_eq(p, trace_field(t, col_sub), $sformatf("subordinate of write %0d", t));
          check_eq(log_addr[p][k], trace_field(t, col_addr), $sformatf("awaddr of write %0d", t));
          check_eq(log_strb[p][k], trace_field(t, col_strb), $sformatf("wstrb of write %0d", t));
          // managers 0 and 2 contend for out0 and trade the grant
          if (p == 0 && k < fair_len) begin
            check_eq(trace_field(t, col_mgr), (k % 2 == 0) ? 0 : 2,
                     $sformatf("manager of out0 write %0d", k));
          end
        end
        overlap[p] = overlap[p] | log_overlap[p][k];
      end
    end
    for (int i = 0; i < num_writes; i++) begin
      check_eq(seen[i], 1, $sformatf("write %0d delivered", i));
    end
    for (int p = 0; p < 2; p++) begin
      check_eq(overlap[p], 1, $sformatf("out%0d write while the other port was busy", p));
    end
  endtask

  initial begin
    int   m;
    logic all_done;
    logic timed_out;
    axi_resetn <= 1'b0;
    for (int i = 0; i < num_mgr; i++) begin
      m_awaddr[i]  <= '0;
      m_awvalid[i] <= 1'b0;
      m_wdata[i]   <= '0;
      m_wstrb[i]   <= '0;
      m_wvalid[i]  <= 1'b0;
      m_bready[i]  <= 1'b0;
    end
    for (int p = 0; p < 2; p++) begin
      s_awready[p] <= 1'b0;
      s_wready[p]  <= 1'b0;
      s_bvalid[p]  <= 1'b0;
      s_bresp[p]   <= 2'b00;
    end
    $readmemh("test/wr_trace.txt", trace_mem);
    // per manager issue queues in file order
    for (int i = 0; i < num_mgr; i++) begin
      mgr_cnt[i] = 0;
    end
    for (int t = 0; t < num_writes; t++) begin
      m = int'(trace_field(t, col_mgr));
      mgr_list[m][mgr_cnt[m]] = t;
      mgr_cnt[m]++;
    end
    repeat (10) @(posedge axi_clk);
    axi_resetn <= 1'b1;
    all_done  = 1'b0;
    timed_out = 1'b0;
    // sampled mid-cycle, away from the clocked models
    while (!all_done && !timed_out) begin
      @(negedge axi_clk);
      cycles++;
      all_done = 1'b1;
      for (int i = 0; i < num_mgr; i++) begin
        if (b_cnt[i] != mgr_cnt[i]) begin
          all_done = 1'b0;
        end
      end
      if (cycles >= cycle_limit) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      errors++;
      $display("timeout after %0d cycles with writes still waiting for a response", cycles);
    end else begin
      check_logs();
    end
    $display("%0d errors over %0d writes in %0d cycles", errors, num_writes, cycles);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_wr_3to2.f
hw/axi_xbar_pkg.sv
hw/grant_fifo.sv
hw/grant_arbiter.sv
hw/axi_write_port.sv
hw/manager_merge.sv
hw/axi_wr_3to2.sv
test/tb_axi_wr_3to2.sv

// File: Makefile
TOP := tb_axi_wr_3to2

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f axi_wr_3to2.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/wr_trace.txt
// mgr  awaddr  wdata  wstrb  sub  bresp   (hex, one write per line, issue order per manager)
// sub is awaddr bit 0, bresp is awaddr bits 2:1 (0 OKAY, 2 SLVERR)
0 00100 0a01 3 0 0
0 00108 0a02 1 0 0
0 0010c 0a03 2 0 2
0 00110 0a04 3 0 0
0 00201 0a05 3 1 0
0 00205 0a06 1 1 2
0 00209 0a07 3 1 0
1 10001 1b01 3 1 0
1 10009 1b02 2 1 0
1 1000d 1b03 3 1 2
1 10011 1b04 1 1 0
1 10019 1b05 3 1 0
1 10021 1b06 3 1 0
1 10025 1b07 2 1 2
1 10029 1b08 3 1 0
2 f0000 2c01 3 0 0
2 f0004 2c02 3 0 2
2 f0008 2c03 1 0 0
2 f0010 2c04 2 0 0
2 f0101 2c05 3 1 0
2 f010d 2c06 3 1 2
2 f0208 2c07 3 0 0
